// File: logic/RasterizerPkg.sv
`default_nettype none

package RasterizerPkg;
    // Screen coordinate widths, enough for a 2048 by 2048 screen
    localparam int XBitWidth = 11;
    localparam int YBitWidth = 11;
    // Edge-function values are 32 bit fixed point numbers from software
    localparam int AttributeSize = 32;
    localparam int FbIndexWidth = 14;
    // Coordinates are zero padded to this width in the fragment payload
    localparam int CoordFieldWidth = 16;

    typedef logic [XBitWidth - 1 : 0] xCoord_t;
    typedef logic [YBitWidth - 1 : 0] yCoord_t;
    // A negative value marks a pixel on the outer side of that edge
    typedef logic signed [AttributeSize - 1 : 0] edgeValue_t;
    typedef logic [FbIndexWidth - 1 : 0] fbIndex_t;

    // Triangle as prepared by software; the box end is exclusive
    typedef struct packed {
        xCoord_t bbStartX;
        yCoord_t bbStartY;
        xCoord_t bbEndX;
        yCoord_t bbEndY;
        edgeValue_t w0;
        edgeValue_t w1;
        edgeValue_t w2;
        edgeValue_t w0IncX;
        edgeValue_t w1IncX;
        edgeValue_t w2IncX;
        edgeValue_t w0IncY;
        edgeValue_t w1IncY;
        edgeValue_t w2IncY;
    } triangle_t;

    // Current framebuffer band and the viewport size
    typedef struct packed {
        yCoord_t yOffset;
        xCoord_t xResolution;
        yCoord_t yResolution;
    } lineConfig_t;

    // Payload of one fragment beat, most significant field first
    typedef struct packed {
        logic [AttributeSize - 1 : 0] fbIndex;
        logic [CoordFieldWidth - 1 : 0] screenY;
        logic [CoordFieldWidth - 1 : 0] screenX;
        logic [CoordFieldWidth - 1 : 0] relY;
        logic [CoordFieldWidth - 1 : 0] relX;
    } fragment_t;

    typedef enum logic [1 : 0] {stepHold, stepRight, stepLeft, stepDown} stepCmd_t;
    typedef enum logic [1 : 0] {waitForCommand, init, test} rasterState_t;
    typedef enum logic [2 : 0] {walkInit, searchEdge, walkOut, walk, checkDirection} walkState_t;
endpackage

`default_nettype wire

// File: logic/TriangleSetup.sv
`timescale 1ns/1ps
`default_nettype none

module TriangleSetup import RasterizerPkg::*;
(
    input  wire              clk,
    input  wire              reset,
    input  wire              startRendering,
    input  wire lineConfig_t lineConfig,
    input  wire triangle_t   triangle,
    output logic             load,
    output xCoord_t          startX,
    output yCoord_t          startY,
    output yCoord_t          startYScreen,
    output edgeValue_t       startW0,
    output edgeValue_t       startW1,
    output edgeValue_t       startW2,
    output yCoord_t          yScreenEnd
);
    // Number of box lines that lie above the band start
    yCoord_t lineBBStart;
    edgeValue_t skippedLines;
    yCoord_t bandEnd;
    logic boxStartsInBand;

    // The load pulse marks the cycle after the start pulse
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            load <= 1'b0;
        end
        else
        begin
            load <= startRendering;
        end
    end

    // Only meaningful when the box starts above the band
    always_ff @(posedge clk)
    begin
        if (startRendering)
        begin
            lineBBStart <= lineConfig.yOffset - triangle.bbStartY;
        end
    end

    assign boxStartsInBand = lineConfig.yOffset <= triangle.bbStartY;
    assign skippedLines = edgeValue_t'(lineBBStart);
    assign bandEnd = lineConfig.yOffset + lineConfig.yResolution;
    assign startX = triangle.bbStartX;

    always_comb
    begin
        if (boxStartsInBand)
        begin
            // The box origin lies in or below the band, so the origin values stay valid
            startY = triangle.bbStartY - lineConfig.yOffset;
            startYScreen = triangle.bbStartY;
            startW0 = triangle.w0;
            startW1 = triangle.w1;
            startW2 = triangle.w2;
        end
        else
        begin
            // Move the edge values down to the first line of the band
            startY = '0;
            startYScreen = lineConfig.yOffset;
            startW0 = triangle.w0 + triangle.w0IncY * skippedLines;
            startW1 = triangle.w1 + triangle.w1IncY * skippedLines;
            startW2 = triangle.w2 + triangle.w2IncY * skippedLines;
        end
    end

    // Clamp the walk to the band end; a box below or above the band ends at once
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            if (bandEnd <= triangle.bbEndY)
            begin
                yScreenEnd <= bandEnd;
            end
            else
            begin
                yScreenEnd <= triangle.bbEndY;
            end
        end
    end

    loadIsPulse: assert property (@(posedge clk) disable iff (reset) load |=> !load);
endmodule

`default_nettype wire

// File: logic/EdgeStepper.sv
`timescale 1ns/1ps
`default_nettype none

module EdgeStepper import RasterizerPkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire             load,
    input  wire xCoord_t    startX,
    input  wire yCoord_t    startY,
    input  wire yCoord_t    startYScreen,
    input  wire edgeValue_t startW0,
    input  wire edgeValue_t startW1,
    input  wire edgeValue_t startW2,
    input  wire             advance,
    input  wire stepCmd_t   stepCmd,
    input  wire triangle_t  triangle,
    output xCoord_t         x,
    output yCoord_t         y,
    output yCoord_t         yScreen,
    output logic            isInTriangle
);
    // Edge-function accumulators for the current pixel
    edgeValue_t w0;
    edgeValue_t w1;
    edgeValue_t w2;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            x <= '0;
            y <= '0;
            yScreen <= '0;
            w0 <= '0;
            w1 <= '0;
            w2 <= '0;
        end
        else if (load)
        begin
            x <= startX;
            y <= startY;
            yScreen <= startYScreen;
            w0 <= startW0;
            w1 <= startW1;
            w2 <= startW2;
        end
        else if (advance)
        begin
            case (stepCmd)
                stepRight:
                begin
                    x <= x + 1'b1;
                    w0 <= w0 + triangle.w0IncX;
                    w1 <= w1 + triangle.w1IncX;
                    w2 <= w2 + triangle.w2IncX;
                end
                stepLeft:
                begin
                    x <= x - 1'b1;
                    w0 <= w0 - triangle.w0IncX;
                    w1 <= w1 - triangle.w1IncX;
                    w2 <= w2 - triangle.w2IncX;
                end
                stepDown:
                begin
                    // y is band relative, yScreen is the absolute line
                    y <= y + 1'b1;
                    yScreen <= yScreen + 1'b1;
                    w0 <= w0 + triangle.w0IncY;
                    w1 <= w1 + triangle.w1IncY;
                    w2 <= w2 + triangle.w2IncY;
                end
                default:
                begin
                end
            endcase
        end
    end

    // Inside when no edge function is negative
    assign isInTriangle = !(w0[AttributeSize - 1] | w1[AttributeSize - 1] | w2[AttributeSize - 1]);
endmodule

`default_nettype wire

// File: logic/EdgeWalker.sv
`timescale 1ns/1ps
`default_nettype none

module EdgeWalker import RasterizerPkg::*;
(
    input  wire            clk,
    input  wire            reset,
    input  wire            startRendering,
    output logic           advance,
    input  wire            fragReady,
    input  wire triangle_t triangle,
    input  wire yCoord_t   yScreenEnd,
    input  wire xCoord_t   x,
    input  wire yCoord_t   yScreen,
    input  wire            isInTriangle,
    output stepCmd_t       stepCmd,
    output logic           rasterizerRunning,
    output logic           fragValid,
    output logic           fragKeep,
    output logic           fragLast
);
    rasterState_t rasterState;
    walkState_t walkState;
    // High while the walk moves toward larger x
    logic walkRight;
    // Set once a line search has turned around at a box edge
    logic tryOtherSide;
    logic hit;
    logic atBoxStart;
    logic atBoxEnd;
    logic releaseStream;

    assign hit = isInTriangle && (x >= triangle.bbStartX) && (x < triangle.bbEndX);
    assign atBoxStart = x == triangle.bbStartX;
    assign atBoxEnd = x == triangle.bbEndX;
    assign advance = (rasterState == test) && fragReady;
    // The closing beat may only be dropped once it has transferred
    assign releaseStream = fragReady || !fragValid;

    always_comb
    begin
        if ((walkState == walkInit) || (walkState == checkDirection))
        begin
            stepCmd = stepHold;
        end
        else if ((walkState == walk) && !hit)
        begin
            stepCmd = stepDown;
        end
        else
        begin
            stepCmd = walkRight ? stepRight : stepLeft;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rasterState <= waitForCommand;
            walkState <= walkInit;
            walkRight <= 1'b1;
            tryOtherSide <= 1'b0;
            rasterizerRunning <= 1'b0;
            fragValid <= 1'b0;
            fragKeep <= 1'b1;
            fragLast <= 1'b0;
        end
        else
        begin
            case (rasterState)
                waitForCommand:
                begin
                    if (releaseStream)
                    begin
                        fragValid <= 1'b0;
                        fragKeep <= 1'b1;
                        fragLast <= 1'b0;
                        rasterizerRunning <= startRendering;
                        if (startRendering)
                        begin
                            rasterState <= init;
                        end
                    end
                end
                init:
                begin
                    // The stepper loads its start values during this cycle
                    walkState <= walkInit;
                    walkRight <= 1'b1;
                    tryOtherSide <= 1'b0;
                    rasterState <= test;
                end
                test:
                begin
                    if (advance && (yScreen < yScreenEnd))
                    begin
                        // Pixels are emitted only while searching or walking a span
                        fragValid <= hit && ((walkState == walk) || (walkState == searchEdge));
                        case (walkState)
                            walkInit:
                            begin
                                walkState <= isInTriangle ? walk : searchEdge;
                            end
                            checkDirection:
                            begin
                                if (isInTriangle)
                                begin
                                    walkState <= walkOut;
                                end
                                else
                                begin
                                    // The span most likely lies behind us
                                    walkRight <= !walkRight;
                                    walkState <= searchEdge;
                                end
                            end
                            searchEdge:
                            begin
                                if (hit)
                                begin
                                    tryOtherSide <= 1'b0;
                                    walkState <= walk;
                                end
                                else if (atBoxEnd || atBoxStart)
                                begin
                                    // Second edge without a hit means an empty line
                                    if (tryOtherSide && (walkRight == atBoxEnd))
                                    begin
                                        tryOtherSide <= 1'b0;
                                        walkState <= walk;
                                    end
                                    else
                                    begin
                                        tryOtherSide <= 1'b1;
                                        walkRight <= atBoxStart;
                                    end
                                end
                            end
                            walkOut:
                            begin
                                if (!isInTriangle || atBoxStart || (x >= triangle.bbEndX))
                                begin
                                    walkRight <= !walkRight;
                                    walkState <= searchEdge;
                                end
                            end
                            walk:
                            begin
                                if (!hit)
                                begin
                                    walkState <= checkDirection;
                                end
                            end
                            default:
                            begin
                                walkState <= walkInit;
                            end
                        endcase
                    end
                    else if (advance)
                    begin
                        // Below the band or the box, so close the stream
                        fragValid <= 1'b1;
                        fragKeep <= 1'b0;
                        fragLast <= 1'b1;
                        rasterState <= waitForCommand;
                    end
                end
                default:
                begin
                    rasterState <= waitForCommand;
                end
            endcase
        end
    end

    lastIsValid: assert property (@(posedge clk) disable iff (reset) fragLast |-> fragValid);
    keepLowOnLast: assert property (@(posedge clk) disable iff (reset) fragKeep == !fragLast);
    // A turning cycle must leave the walk position where it is
    holdWhileTurning: assert property (@(posedge clk) disable iff (reset)
        (advance && ((walkState == walkInit) || (walkState == checkDirection)))
        |=> ($stable(x) && $stable(yScreen)));
endmodule

`default_nettype wire

// File: logic/FragmentPacker.sv
`timescale 1ns/1ps
`default_nettype none

module FragmentPacker import RasterizerPkg::*;
(
    input  wire              clk,
    input  wire              reset,
    input  wire              advance,
    input  wire lineConfig_t lineConfig,
    input  wire triangle_t   triangle,
    input  wire xCoord_t     x,
    input  wire yCoord_t     y,
    input  wire yCoord_t     yScreen,
    output fragment_t        fragData
);
    // Last index that was inside the viewport
    fbIndex_t lastIndex;
    fbIndex_t nextIndex;
    yCoord_t mirroredLine;
    logic [XBitWidth + YBitWidth - 1 : 0] rawIndex;
    logic inViewport;

    assign inViewport = (y < lineConfig.yResolution) && (x < lineConfig.xResolution);
    // The framebuffer stores lines bottom up
    assign mirroredLine = lineConfig.yResolution - 1'b1 - y;
    assign rawIndex = {{XBitWidth{1'b0}}, mirroredLine} * {{YBitWidth{1'b0}}, lineConfig.xResolution}
        + {{YBitWidth{1'b0}}, x};
    assign nextIndex = inViewport ? fbIndex_t'(rawIndex) : lastIndex;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lastIndex <= '0;
        end
        else if (advance)
        begin
            lastIndex <= nextIndex;
        end
    end

    // Registered together with fragValid in the walker
    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            fragData.fbIndex <= AttributeSize'(nextIndex);
            fragData.screenY <= CoordFieldWidth'(yScreen);
            fragData.screenX <= CoordFieldWidth'(x);
            fragData.relY <= CoordFieldWidth'(yCoord_t'(yScreen - triangle.bbStartY));
            fragData.relX <= CoordFieldWidth'(xCoord_t'(x - triangle.bbStartX));
        end
    end
endmodule

`default_nettype wire

// File: logic/Rasterizer.sv
`timescale 1ns/1ps
`default_nettype none

module Rasterizer import RasterizerPkg::*;
(
    input  wire              clk,
    input  wire              reset,
    input  wire              startRendering,
    output wire              rasterizerRunning,
    input  wire lineConfig_t lineConfig,
    input  wire triangle_t   triangle,
    output wire              fragValid,
    input  wire              fragReady,
    output wire              fragLast,
    output wire              fragKeep,
    output wire fragment_t   fragData
);
    // Setup to stepper and walker
    logic load;
    xCoord_t startX;
    yCoord_t startY;
    yCoord_t startYScreen;
    edgeValue_t startW0;
    edgeValue_t startW1;
    edgeValue_t startW2;
    yCoord_t yScreenEnd;
    // Walker control toward the datapath
    stepCmd_t stepCmd;
    logic advance;
    // Current walk position
    xCoord_t x;
    yCoord_t y;
    yCoord_t yScreen;
    logic isInTriangle;

    TriangleSetup setup0 (.clk, .reset, .startRendering, .lineConfig, .triangle, .load,
        .startX, .startY, .startYScreen, .startW0, .startW1, .startW2, .yScreenEnd);

    EdgeStepper stepper0 (.clk, .reset, .load, .startX, .startY, .startYScreen,
        .startW0, .startW1, .startW2, .advance, .stepCmd, .triangle,
        .x, .y, .yScreen, .isInTriangle);

    EdgeWalker walker0 (.clk, .reset, .startRendering, .advance, .fragReady, .triangle,
        .yScreenEnd, .x, .yScreen, .isInTriangle, .stepCmd, .rasterizerRunning,
        .fragValid, .fragKeep, .fragLast);

    FragmentPacker packer0 (.clk, .reset, .advance, .lineConfig, .triangle,
        .x, .y, .yScreen, .fragData);
endmodule

`default_nettype wire

// File: sim/RasterizerModel.svh
`ifndef RASTERIZER_MODEL_SVH
`define RASTERIZER_MODEL_SVH

// Vertices of the current triangle in screen pixels
int vertX[3];
int vertY[3];

// Edge function of the edge from a to b, evaluated at pixel p
function automatic int edgeFunction(input int ax, input int ay, input int bx, input int by,
    input int px, input int py);
    return (px - ax) * (by - ay) - (py - ay) * (bx - ax);
endfunction

// A pixel is covered when no edge function is negative
function automatic bit insideTriangle(input int px, input int py);
    return (edgeFunction(vertX[1], vertY[1], vertX[2], vertY[2], px, py) >= 0)
        && (edgeFunction(vertX[2], vertY[2], vertX[0], vertY[0], px, py) >= 0)
        && (edgeFunction(vertX[0], vertY[0], vertX[1], vertY[1], px, py) >= 0);
endfunction

// Builds the setup values that software would hand to the rasterizer
function automatic triangle_t buildTriangle();
    triangle_t shape;
    int keep;
    int minX;
    int maxX;
    int minY;
    int maxY;
    int i;
    // Swapping two vertices flips the orientation so the inside is non negative
    if (edgeFunction(vertX[0], vertY[0], vertX[1], vertY[1], vertX[2], vertY[2]) < 0)
    begin
        keep = vertX[1];
        vertX[1] = vertX[2];
        vertX[2] = keep;
        keep = vertY[1];
        vertY[1] = vertY[2];
        vertY[2] = keep;
    end
    minX = vertX[0];
    maxX = vertX[0];
    minY = vertY[0];
    maxY = vertY[0];
    for (i = 1; i < 3; i++)
    begin
        minX = (vertX[i] < minX) ? vertX[i] : minX;
        maxX = (vertX[i] > maxX) ? vertX[i] : maxX;
        minY = (vertY[i] < minY) ? vertY[i] : minY;
        maxY = (vertY[i] > maxY) ? vertY[i] : maxY;
    end
    // Box end is exclusive
    shape.bbStartX = xCoord_t'(minX);
    shape.bbEndX = xCoord_t'(maxX + 1);
    shape.bbStartY = yCoord_t'(minY);
    shape.bbEndY = yCoord_t'(maxY + 1);
    shape.w0 = edgeFunction(vertX[1], vertY[1], vertX[2], vertY[2], minX, minY);
    shape.w1 = edgeFunction(vertX[2], vertY[2], vertX[0], vertY[0], minX, minY);
    shape.w2 = edgeFunction(vertX[0], vertY[0], vertX[1], vertY[1], minX, minY);
    shape.w0IncX = vertY[2] - vertY[1];
    shape.w1IncX = vertY[0] - vertY[2];
    shape.w2IncX = vertY[1] - vertY[0];
    shape.w0IncY = vertX[1] - vertX[2];
    shape.w1IncY = vertX[2] - vertX[0];
    shape.w2IncY = vertX[0] - vertX[1];
    return shape;
endfunction

function automatic bit inBoxAndBand(input lineConfig_t cfg, input triangle_t shape,
    input int px, input int py);
    return (px >= int'(shape.bbStartX)) && (px < int'(shape.bbEndX))
        && (py >= int'(shape.bbStartY)) && (py < int'(shape.bbEndY))
        && (py >= int'(cfg.yOffset)) && (py < int'(cfg.yOffset) + int'(cfg.yResolution));
endfunction

// Payload of a pixel, with the framebuffer stored bottom line first
function automatic fragment_t expectedFragment(input lineConfig_t cfg, input triangle_t shape,
    input int px, input int py);
    fragment_t frag;
    int bandLine;
    int index;
    bandLine = py - int'(cfg.yOffset);
    index = (int'(cfg.yResolution) - 1 - bandLine) * int'(cfg.xResolution) + px;
    frag.fbIndex = 32'(index);
    frag.screenY = 16'(py);
    frag.screenX = 16'(px);
    frag.relY = 16'(py - int'(shape.bbStartY));
    frag.relX = 16'(px - int'(shape.bbStartX));
    return frag;
endfunction

// Counts the covered pixels of the band and flags whether every line spans two or more
function automatic int coveredPixels(input lineConfig_t cfg, input triangle_t shape,
    output bit wideSpans);
    int total;
    int span;
    int px;
    int py;
    total = 0;
    wideSpans = 1'b1;
    for (py = int'(cfg.yOffset); py < int'(cfg.yOffset) + int'(cfg.yResolution); py++)
    begin
        if ((py >= int'(shape.bbStartY)) && (py < int'(shape.bbEndY)))
        begin
            span = 0;
            for (px = int'(shape.bbStartX); px < int'(shape.bbEndX); px++)
            begin
                span += insideTriangle(px, py) ? 1 : 0;
            end
            wideSpans = wideSpans && (span >= 2);
            total += span;
        end
    end
    return total;
endfunction

`endif

// File: sim/RasterizerTb.sv
`timescale 1ns/1ps
`default_nettype none

module RasterizerTb import RasterizerPkg::*; ();
    localparam int TestCount = 20;
    localparam int CyclesPerTest = 4096;
    localparam int CycleLimit = TestCount * CyclesPerTest;
    localparam int BandHeight = 16;
    localparam int ScreenWidth = 64;

    logic clk;
    logic reset;
    logic startRendering;
    logic rasterizerRunning;
    lineConfig_t lineConfig;
    triangle_t triangle;
    logic fragValid;
    logic fragReady;
    logic fragLast;
    logic fragKeep;
    fragment_t fragData;

    integer seed;
    // Holds fragReady high instead of drawing it at random
    bit readyAlways;
    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int testErrors = 0;
    int testsRun = 0;
    int failedTests = 0;
    string testName;
    // Data beats of the most recent run, in stream order
    fragment_t beats[$];
    bit hits [ScreenWidth][ScreenWidth];

    `include "RasterizerModel.svh"

    Rasterizer dut0 (.clk, .reset, .startRendering, .rasterizerRunning, .lineConfig, .triangle,
        .fragValid, .fragReady, .fragLast, .fragKeep, .fragData);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Sink back-pressure, about 70 percent ready
    always @(posedge clk)
    begin
        fragReady <= readyAlways ? 1'b1 : (($unsigned($random(seed)) % 100) < 70);
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= CycleLimit)
        begin
            $display("Cycle limit of %0d reached before the fragment stream closed", CycleLimit);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic checkFragment(input string what, input fragment_t expected,
        input fragment_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            testErrors++;
            $display("ERR %s %s expected %h actual %h", testName, what, expected, actual);
        end
    endtask

    task automatic checkCount(input string what, input int expected, input int actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            testErrors++;
            $display("ERR %s %s expected %0d actual %0d", testName, what, expected, actual);
        end
    endtask

    task automatic checkFlag(input string what, input bit expected, input bit actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            testErrors++;
            $display("ERR %s %s expected %0b actual %0b", testName, what, expected, actual);
        end
    endtask

    task automatic randomConfig(output lineConfig_t cfg);
        cfg.yOffset = yCoord_t'(BandHeight * ($unsigned($random(seed)) % 4));
        cfg.xResolution = xCoord_t'(ScreenWidth);
        cfg.yResolution = yCoord_t'(BandHeight);
    endtask

    // Draws three vertices with y in yLow up to yLow plus ySpan, rejecting flat triangles
    task automatic makeTriangle(input int yLow, input int ySpan, output triangle_t shape);
        int area;
        int i;
        area = 0;
        while (area == 0)
        begin
            for (i = 0; i < 3; i++)
            begin
                vertX[i] = $unsigned($random(seed)) % ScreenWidth;
                vertY[i] = yLow + ($unsigned($random(seed)) % ySpan);
            end
            area = edgeFunction(vertX[0], vertY[0], vertX[1], vertY[1], vertX[2], vertY[2]);
        end
        shape = buildTriangle();
    endtask

    // Starts one run and collects beats at the falling edge until the closing beat
    task automatic runTriangle(input lineConfig_t cfg, input triangle_t shape);
        bit done;
        done = 1'b0;
        beats.delete();
        @(posedge clk);
        lineConfig <= cfg;
        triangle <= shape;
        startRendering <= 1'b1;
        @(posedge clk);
        startRendering <= 1'b0;
        while (!done)
        begin
            @(negedge clk);
            checkFlag("running during walk", 1'b1, rasterizerRunning);
            if (fragValid && fragReady)
            begin
                if (fragLast || !fragKeep)
                begin
                    checkFlag("keep on closing beat", 1'b0, fragKeep);
                    checkFlag("last on closing beat", 1'b1, fragLast);
                    done = 1'b1;
                end
                else
                begin
                    beats.push_back(fragData);
                end
            end
        end
        // The closing beat transfers on the next edge and the stream goes idle
        @(negedge clk);
        checkFlag("running after closing beat", 1'b0, rasterizerRunning);
        checkFlag("valid after closing beat", 1'b0, fragValid);
    endtask

    task automatic checkBeats(input lineConfig_t cfg, input triangle_t shape);
        int px;
        int py;
        int distinct;
        int duplicates;
        int expected;
        bit wideSpans;
        for (py = 0; py < ScreenWidth; py++)
        begin
            for (px = 0; px < ScreenWidth; px++)
            begin
                hits[py][px] = 1'b0;
            end
        end
        distinct = 0;
        duplicates = 0;
        foreach (beats[i])
        begin
            px = int'(beats[i].screenX);
            py = int'(beats[i].screenY);
            checkFlag("pixel inside triangle", 1'b1, insideTriangle(px, py));
            checkFlag("pixel inside box and band", 1'b1, inBoxAndBand(cfg, shape, px, py));
            checkFragment("payload", expectedFragment(cfg, shape, px, py), beats[i]);
            if ((px < ScreenWidth) && (py < ScreenWidth))
            begin
                if (hits[py][px])
                begin
                    duplicates++;
                end
                else
                begin
                    distinct++;
                end
                hits[py][px] = 1'b1;
            end
        end
        expected = coveredPixels(cfg, shape, wideSpans);
        // Thin spans may be skipped by the walker, so coverage is only compared on wide ones
        if (wideSpans)
        begin
            checkCount("duplicate pixels", 0, duplicates);
            checkCount("covered pixels", expected, distinct);
        end
    endtask

    task automatic finishTest();
        testsRun++;
        if (testErrors > 0)
        begin
            failedTests++;
        end
        $display("Test %0d %s done, %0d data beats, %0d errors", testsRun, testName,
            beats.size(), testErrors);
        testErrors = 0;
    endtask

    initial
    begin : stimulus
        lineConfig_t cfg;
        triangle_t shape;
        fragment_t refBeats[$];
        int t;
        int i;
        seed = 32'h30d8_080c;
        reset = 1'b1;
        startRendering = 1'b0;
        fragReady = 1'b0;
        lineConfig = '0;
        triangle = '0;
        readyAlways = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        testName = "resetValues";
        checkFlag("valid", 1'b0, fragValid);
        checkFlag("last", 1'b0, fragLast);
        checkFlag("keep", 1'b1, fragKeep);
        checkFlag("running", 1'b0, rasterizerRunning);
        $display("Reset values checked, %0d errors", testErrors);
        testErrors = 0;

        for (t = 0; t < 14; t++)
        begin
            testName = "randomTriangle";
            randomConfig(cfg);
            makeTriangle(0, ScreenWidth, shape);
            runTriangle(cfg, shape);
            checkBeats(cfg, shape);
            finishTest();
        end

        // Same triangle once without and once with back-pressure
        for (t = 0; t < 4; t++)
        begin
            testName = "backPressure";
            randomConfig(cfg);
            makeTriangle(0, ScreenWidth, shape);
            readyAlways = 1'b1;
            runTriangle(cfg, shape);
            refBeats = beats;
            readyAlways = 1'b0;
            runTriangle(cfg, shape);
            checkBeats(cfg, shape);
            checkCount("sequence length", refBeats.size(), beats.size());
            for (i = 0; (i < refBeats.size()) && (i < beats.size()); i++)
            begin
                checkFragment("sequence beat", refBeats[i], beats[i]);
            end
            finishTest();
        end

        testName = "boxAboveBand";
        makeTriangle(0, BandHeight, shape);
        cfg.yOffset = yCoord_t'(2 * BandHeight);
        cfg.xResolution = xCoord_t'(ScreenWidth);
        cfg.yResolution = yCoord_t'(BandHeight);
        runTriangle(cfg, shape);
        checkCount("data beats", 0, beats.size());
        finishTest();

        testName = "boxBelowBand";
        makeTriangle(3 * BandHeight, BandHeight, shape);
        cfg.yOffset = yCoord_t'(BandHeight);
        runTriangle(cfg, shape);
        checkCount("data beats", 0, beats.size());
        finishTest();

        $display("Tests %0d, tests with errors %0d, checks %0d, errors %0d, cycles %0d",
            testsRun, failedTests, checks, errors, cycles);
        if (errors == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end
endmodule

`default_nettype wire

// File: Rasterizer.f
+incdir+sim
logic/RasterizerPkg.sv
logic/TriangleSetup.sv
logic/EdgeStepper.sv
logic/EdgeWalker.sv
logic/FragmentPacker.sv
logic/Rasterizer.sv
sim/RasterizerTb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module RasterizerTb \
    -f Rasterizer.f -o RasterizerSim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/RasterizerSim > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0
